// File: daq_frame.f
logic/daq_cfg_pkg.sv
logic/daq_frame_pkg.sv
logic/trigger_decode.sv
logic/header_footer_gen.sv
logic/sync_fifo.sv
logic/frame_serializer.sv
logic/daq_frame_top.sv
dv/daq_frame_tb.sv

// File: dv/daq_frame_tb.sv
`timescale 1ns/1ns
`default_nettype none

module daq_frame_tb;

  localparam logic [7:0] CH_ID = 8'h3c;
  localparam int SAMPLE_DEPTH = 128;
  localparam int PAIR_DEPTH = 4;
  localparam int WAIT_LIMIT = 5000;
  localparam int DRAIN_LIMIT = 20000;

  logic                      ACLK;
  logic                      ARESET;
  logic                      cfg_req;
  logic [15:0]               cfg_max_len;
  logic                      cfg_ack;
  daq_frame_pkg::trig_beat_t s_tdata;
  logic                      s_tvalid;
  logic                      s_tready;
  logic [63:0]               m_tdata;
  logic                      m_tvalid;
  logic                      m_tready;
  logic                      m_tlast;

  integer                    seed;
  integer                    ready_seed;
  logic [31:0]               ready_rnd;
  int                        stall_mode;
  int                        stall_phase;
  int                        model_max_len;
  int                        model_obj;
  daq_frame_pkg::trig_beat_t trig[$];
  // bit 64 is the expected tlast
  logic [64:0]               exp_q[$];
  string                     test_name;
  int                        errors;
  int                        test_err_start;
  int                        checks;
  int                        tests_run;
  int                        tests_failed;
  bit                        aborted;
  bit                        saw_stall;

  daq_frame_top #(
    .CHANNEL_ID(CH_ID),
    .SAMPLE_DEPTH(SAMPLE_DEPTH),
    .PAIR_DEPTH(PAIR_DEPTH)
  ) dut0 (
    .ACLK(ACLK), .ARESET(ARESET), .cfg_req(cfg_req), .cfg_max_len(cfg_max_len),
    .cfg_ack(cfg_ack), .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast)
  );

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK;
  end

  // mode 0 always ready, mode 1 short random stalls, mode 2 long periodic stalls
  always @(posedge ACLK) begin
    #1;
    stall_phase = (stall_phase + 1) % 80;
    ready_rnd = $random(ready_seed);
    case (stall_mode)
      0: m_tready = 1'b1;
      1: m_tready = (ready_rnd[1:0] != 2'b00);
      default: m_tready = (stall_phase >= 60);
    endcase
  end

  always @(negedge ACLK) begin
    if (!ARESET && !s_tready) begin
      saw_stall = 1'b1;
    end
  end

  // lines are stable from the negative edge up to the handshake edge
  always @(negedge ACLK) begin
    if (!ARESET && m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected output line %h in test %s, no line was expected",
                 m_tdata, test_name);
      end else begin
        check(test_name, exp_q.pop_front(), {m_tlast, m_tdata});
      end
    end
  end

  task automatic check(input string name, input logic [64:0] expected,
                       input logic [64:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // frames must fit the sample buffer, and a frame has at least one beat
  function automatic int limit_max_len(input int value);
    if (value < 1) begin
      return 1;
    end
    if (value > SAMPLE_DEPTH) begin
      return SAMPLE_DEPTH;
    end
    return value;
  endfunction

  task automatic make_trigger(input int len, input bit full_scale);
    daq_frame_pkg::trig_beat_t b;
    logic [31:0]               r;
    logic [31:0]               ts_lo;
    trig.delete();
    for (int i = 0; i < len; i++) begin
      b = '0;
      for (int k = 0; k < 4; k++) begin
        r = $random(seed);
        b.samples[k] = full_scale ? 16'hffff : r[15:0];
      end
      r = $random(seed);
      ts_lo = $random(seed);
      b.gain_type = r[0];
      b.trigger_type = r[7:4];
      b.trig_config = r[27:16];
      b.timestamp = {r[31:28], ts_lo[11:0], ts_lo};
      trig.push_back(b);
    end
  endtask

  // split by max_len, header fields come from each frame's first beat
  task automatic model_trigger();
    int                        pos;
    int                        len;
    int                        charge;
    bit                        first;
    bit                        cont;
    daq_frame_pkg::trig_beat_t fb;
    pos = 0;
    first = 1'b1;
    while (pos < trig.size()) begin
      len = trig.size() - pos;
      if (len > model_max_len) begin
        len = model_max_len;
      end
      cont = (len == model_max_len);
      fb = trig[pos];
      charge = 0;
      for (int i = 0; i < len; i++) begin
        for (int k = 0; k < 4; k++) begin
          charge = charge + trig[pos + i].samples[k];
        end
      end
      if (charge > 20'hfffff) begin
        charge = 20'hfffff;
      end
      exp_q.push_back({1'b0, 16'haa55, CH_ID, len[15:0], first, cont, fb.gain_type, 1'b0,
                       fb.trigger_type, 16'h0000});
      exp_q.push_back({1'b0, fb.timestamp[31:0], charge[19:0], fb.trig_config});
      for (int i = 0; i < len; i++) begin
        exp_q.push_back({1'b0, trig[pos + i].samples});
      end
      exp_q.push_back({1'b1, fb.timestamp[47:32], model_obj[31:0], 16'h55aa});
      pos = pos + len;
      first = 1'b0;
    end
    model_obj++;
  endtask

  task automatic drive_trigger(input int gap);
    int n;
    bit accepted;
    for (int i = 0; i < trig.size() && !aborted; i++) begin
      s_tdata = trig[i];
      s_tvalid = 1'b1;
      accepted = 1'b0;
      n = 0;
      while (!accepted && n < WAIT_LIMIT) begin
        @(negedge ACLK);
        accepted = s_tready;
        @(posedge ACLK);
        #1;
        n++;
      end
      if (!accepted) begin
        errors++;
        aborted = 1'b1;
        $display("timeout: beat %0d of a trigger in test %s was never accepted", i, test_name);
      end
    end
    s_tvalid = 1'b0;
    repeat (gap) begin
      @(posedge ACLK);
      #1;
    end
  endtask

  task automatic send_trigger(input int len, input bit full_scale);
    make_trigger(len, full_scale);
    model_trigger();
    drive_trigger(1 + rand_below(4));
  endtask

  task automatic configure(input int value);
    int n;
    cfg_max_len = value[15:0];
    cfg_req = 1'b1;
    n = 0;
    while (!cfg_ack && n < WAIT_LIMIT) begin
      @(posedge ACLK);
      #1;
      n++;
    end
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack && n < WAIT_LIMIT) begin
      @(posedge ACLK);
      #1;
      n++;
    end
    if (n == 0 || cfg_ack) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: config handshake for max_len %0d did not complete", value);
    end
    model_max_len = limit_max_len(value);
    model_obj = 0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge ACLK);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: %0d output lines never arrived in test %s", exp_q.size(), test_name);
    end
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
    end else begin
      $display("test %s: passed", test_name);
    end
  endtask

  initial begin
    seed = 32'h4f06;
    ready_seed = 32'h4f06;
    stall_mode = 0;
    stall_phase = 0;
    ARESET = 1'b1;
    cfg_req = 1'b0;
    cfg_max_len = '0;
    s_tdata = '0;
    s_tvalid = 1'b0;
    m_tready = 1'b1;
    model_max_len = limit_max_len(100);
    model_obj = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    test_name = "reset";
    repeat (8) @(posedge ACLK);
    #1;
    ARESET = 1'b0;

    start_test("default_framing");
    stall_mode = 1;
    repeat (6) begin
      if (!aborted) send_trigger(1 + rand_below(99), 1'b0);
    end
    end_test();

    if (!aborted) begin
      start_test("split_trigger");
      configure(5);
      send_trigger(12, 1'b0);
      end_test();
    end

    if (!aborted) begin
      start_test("charge_sum");
      configure(100);
      send_trigger(7, 1'b1);
      send_trigger(4, 1'b1);
      send_trigger(30, 1'b0);
      end_test();
    end

    if (!aborted) begin
      start_test("object_id_config");
      send_trigger(3, 1'b0);
      send_trigger(2, 1'b0);
      // above the sample buffer depth
      configure(500);
      send_trigger(140, 1'b0);
      send_trigger(1, 1'b0);
      configure(0);
      send_trigger(3, 1'b0);
      end_test();
    end

    if (!aborted) begin
      start_test("back_pressure");
      configure(3);
      stall_mode = 2;
      saw_stall = 1'b0;
      repeat (10) begin
        if (!aborted) send_trigger(1 + rand_below(10), 1'b0);
      end
      check("back_pressure", 65'd1, {64'd0, saw_stall});
      end_test();
      stall_mode = 0;
    end

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/daq_cfg_pkg.sv
`default_nettype none

package daq_cfg_pkg;

  // adc sample layout
  localparam int SAMPLE_W = 16;
  localparam int SAMPLES_PER_BEAT = 4;

  // one output line, also one buffered sample word
  localparam int LINE_W = 64;

  // trigger information
  localparam int TS_W = 48;
  localparam int TRIG_TYPE_W = 4;
  localparam int TRIG_CFG_W = 12;

  // charge sum saturates at all ones
  localparam int CHARGE_W = 20;

  localparam int LEN_W = 16;
  localparam int OBJ_W = 32;

  // line markers
  localparam logic [15:0] HEADER_ID = 16'hAA55;
  localparam logic [15:0] FOOTER_ID = 16'h55AA;

  // frame length after reset, before any config write
  localparam logic [LEN_W-1:0] DEFAULT_MAX_LEN = 100;

endpackage

`default_nettype wire

// File: logic/daq_frame_pkg.sv
`default_nettype none

package daq_frame_pkg;

  // one input beat, sample 0 in the lowest bits of samples
  typedef struct packed {
    logic [daq_cfg_pkg::SAMPLES_PER_BEAT-1:0][daq_cfg_pkg::SAMPLE_W-1:0] samples;
    logic                                  gain_type;
    logic [daq_cfg_pkg::TRIG_TYPE_W-1:0]   trigger_type;
    logic [daq_cfg_pkg::TS_W-1:0]          timestamp;
    logic [daq_cfg_pkg::TRIG_CFG_W-1:0]    trig_config;
    logic [14:0]                           pad;
  } trig_beat_t;

  typedef struct packed {
    logic first;
    logic cont;
    logic gain_type;
    logic spare;
  } frame_info_t;

  typedef struct packed {
    logic [15:0]                         header_id;
    logic [7:0]                          ch_id;
    logic [daq_cfg_pkg::LEN_W-1:0]       frame_len;
    frame_info_t                         frame_info;
    logic [daq_cfg_pkg::TRIG_TYPE_W-1:0] trigger_type;
    logic [15:0]                         pad;
  } header_line0_t;

  typedef struct packed {
    logic [31:0]                        timestamp;
    logic [daq_cfg_pkg::CHARGE_W-1:0]   charge_sum;
    logic [daq_cfg_pkg::TRIG_CFG_W-1:0] trig_config;
  } header_line1_t;

  // timestamp here carries bits 47:32
  typedef struct packed {
    logic [15:0]                   timestamp;
    logic [daq_cfg_pkg::OBJ_W-1:0] object_id;
    logic [15:0]                   footer_id;
  } footer_line_t;

  typedef struct packed {
    header_line0_t line0;
    header_line1_t line1;
    footer_line_t  footer;
  } hf_pair_t;

  // last_missing is a trigger end, it carries no beat
  typedef struct packed {
    logic valid;
    logic start;
    logic last_missing;
    logic beat;
  } beat_evt_t;

endpackage

`default_nettype wire

// File: logic/daq_frame_top.sv
`timescale 1ns/1ns
`default_nettype none

module daq_frame_top #(
  parameter int CHANNEL_ID = 0,
  parameter int SAMPLE_DEPTH = 128,
  parameter int PAIR_DEPTH = 8
) (
  input  logic                           ACLK,
  input  logic                           ARESET,
  input  logic                           cfg_req,
  input  logic [daq_cfg_pkg::LEN_W-1:0]  cfg_max_len,
  output logic                           cfg_ack,
  input  daq_frame_pkg::trig_beat_t      s_tdata,
  input  logic                           s_tvalid,
  output logic                           s_tready,
  output logic [daq_cfg_pkg::LINE_W-1:0] m_tdata,
  output logic                           m_tvalid,
  input  logic                           m_tready,
  output logic                           m_tlast
);

  daq_frame_pkg::beat_evt_t       evt;
  daq_frame_pkg::trig_beat_t      beat;
  daq_frame_pkg::hf_pair_t        pair_din;
  daq_frame_pkg::hf_pair_t        pair_dout;
  logic [daq_cfg_pkg::LINE_W-1:0] sample_din;
  logic [daq_cfg_pkg::LINE_W-1:0] sample_dout;
  logic                           trig_open;
  logic                           sample_push;
  logic                           sample_pop;
  logic                           sample_full;
  logic                           sample_empty;
  logic                           pair_push;
  logic                           pair_pop;
  logic                           pair_full;
  logic                           pair_empty;

  assign s_tready = !sample_full && !pair_full;

  trigger_decode u_decode (
    .ACLK(ACLK), .ARESET(ARESET), .s_tdata(s_tdata), .s_tvalid(s_tvalid),
    .s_tready(s_tready), .evt(evt), .beat(beat)
  );

  header_footer_gen #(.CHANNEL_ID(CHANNEL_ID), .SAMPLE_DEPTH(SAMPLE_DEPTH)) u_hf_gen (
    .ACLK(ACLK), .ARESET(ARESET), .cfg_req(cfg_req), .cfg_max_len(cfg_max_len),
    .cfg_ack(cfg_ack), .evt(evt), .beat(beat), .trig_open(trig_open),
    .sample_push(sample_push), .sample_word(sample_din),
    .pair_push(pair_push), .pair(pair_din)
  );

  sync_fifo #(.WIDTH(daq_cfg_pkg::LINE_W), .DEPTH(SAMPLE_DEPTH)) u_sample_fifo (
    .ACLK(ACLK), .ARESET(ARESET), .push(sample_push), .din(sample_din),
    .full(sample_full), .pop(sample_pop), .dout(sample_dout), .empty(sample_empty)
  );

  sync_fifo #(.WIDTH($bits(daq_frame_pkg::hf_pair_t)), .DEPTH(PAIR_DEPTH)) u_pair_fifo (
    .ACLK(ACLK), .ARESET(ARESET), .push(pair_push), .din(pair_din),
    .full(pair_full), .pop(pair_pop), .dout(pair_dout), .empty(pair_empty)
  );

  frame_serializer u_serializer (
    .ACLK(ACLK), .ARESET(ARESET), .pair(pair_dout), .pair_empty(pair_empty),
    .pair_pop(pair_pop), .sample_word(sample_dout), .sample_empty(sample_empty),
    .sample_pop(sample_pop), .m_tdata(m_tdata), .m_tvalid(m_tvalid),
    .m_tready(m_tready), .m_tlast(m_tlast)
  );

  // decode only starts a trigger once the generator has closed the last one
  assert property (@(posedge ACLK) disable iff (ARESET) evt.start |-> !trig_open);

endmodule

`default_nettype wire

// File: logic/frame_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_serializer (
  input  logic                           ACLK,
  input  logic                           ARESET,
  input  daq_frame_pkg::hf_pair_t        pair,
  input  logic                           pair_empty,
  output logic                           pair_pop,
  input  logic [daq_cfg_pkg::LINE_W-1:0] sample_word,
  input  logic                           sample_empty,
  output logic                           sample_pop,
  output logic [daq_cfg_pkg::LINE_W-1:0] m_tdata,
  output logic                           m_tvalid,
  input  logic                           m_tready,
  output logic                           m_tlast
);

  localparam logic [1:0] S_LINE0 = 2'd0;
  localparam logic [1:0] S_LINE1 = 2'd1;
  localparam logic [1:0] S_SAMPLES = 2'd2;
  localparam logic [1:0] S_FOOTER = 2'd3;

  logic [1:0]                    state;
  logic [daq_cfg_pkg::LEN_W-1:0] word_cnt;
  logic                          last_word;

  assign last_word = (word_cnt + 1'b1 == pair.line0.frame_len);

  // all lines come straight from fifo heads, which hold until popped
  always_comb begin
    case (state)
      S_LINE0: begin
        m_tdata = pair.line0;
        m_tvalid = !pair_empty;
      end
      S_LINE1: begin
        m_tdata = pair.line1;
        m_tvalid = 1'b1;
      end
      S_SAMPLES: begin
        m_tdata = sample_word;
        m_tvalid = !sample_empty;
      end
      default: begin
        m_tdata = pair.footer;
        m_tvalid = 1'b1;
      end
    endcase
  end

  assign m_tlast = (state == S_FOOTER);
  assign sample_pop = (state == S_SAMPLES) && !sample_empty && m_tready;
  assign pair_pop = (state == S_FOOTER) && m_tready;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state <= S_LINE0;
      word_cnt <= '0;
    end else begin
      case (state)
        S_LINE0: begin
          if (!pair_empty && m_tready) begin
            state <= S_LINE1;
          end
        end
        S_LINE1: begin
          if (m_tready) begin
            state <= S_SAMPLES;
            word_cnt <= '0;
          end
        end
        S_SAMPLES: begin
          if (sample_pop) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              state <= S_FOOTER;
            end
          end
        end
        default: begin
          if (m_tready) begin
            state <= S_LINE0;
          end
        end
      endcase
    end
  end

  assert property (@(posedge ACLK) disable iff (ARESET)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

`default_nettype wire

// File: logic/header_footer_gen.sv
`timescale 1ns/1ns
`default_nettype none

module header_footer_gen #(
  parameter int CHANNEL_ID = 0,
  parameter int SAMPLE_DEPTH = 128
) (
  input  logic                               ACLK,
  input  logic                               ARESET,
  input  logic                               cfg_req,
  input  logic [daq_cfg_pkg::LEN_W-1:0]      cfg_max_len,
  output logic                               cfg_ack,
  input  daq_frame_pkg::beat_evt_t           evt,
  input  daq_frame_pkg::trig_beat_t          beat,
  output logic                               trig_open,
  output logic                               sample_push,
  output logic [daq_cfg_pkg::LINE_W-1:0]     sample_word,
  output logic                               pair_push,
  output daq_frame_pkg::hf_pair_t            pair
);

  localparam logic [daq_cfg_pkg::LEN_W-1:0] DEPTH_LEN =
    SAMPLE_DEPTH[daq_cfg_pkg::LEN_W-1:0];

  logic [daq_cfg_pkg::LEN_W-1:0]    max_len;
  logic [daq_cfg_pkg::LEN_W-1:0]    cur_len;
  logic [daq_cfg_pkg::LEN_W-1:0]    close_len;
  logic [daq_cfg_pkg::SAMPLE_W+1:0] beat_sum;
  logic [daq_cfg_pkg::CHARGE_W:0]   charge_sum;
  logic [daq_cfg_pkg::CHARGE_W-1:0] charge_q;
  logic [daq_cfg_pkg::CHARGE_W-1:0] charge_next;
  logic [daq_cfg_pkg::CHARGE_W-1:0] close_charge;
  logic [daq_cfg_pkg::OBJ_W-1:0]    object_id;
  logic                             first_q;
  logic                             new_frame;
  logic                             len_hit;
  logic                             cfg_write;
  logic                             frame_has_beat;
  daq_frame_pkg::trig_beat_t        first_beat_q;
  daq_frame_pkg::trig_beat_t        info;
  daq_frame_pkg::frame_info_t       finfo;

  // keeps a whole frame inside the sample buffer
  function automatic logic [daq_cfg_pkg::LEN_W-1:0] clamp_len(
    input logic [daq_cfg_pkg::LEN_W-1:0] len
  );
    if (len == '0) begin
      return 1;
    end
    if (len > DEPTH_LEN) begin
      return DEPTH_LEN;
    end
    return len;
  endfunction

  assign cfg_write = cfg_req && !cfg_ack && !trig_open && !evt.valid;

  assign new_frame = (cur_len == '0);
  // a frame takes its trigger fields from its first beat
  assign info = new_frame ? beat : first_beat_q;

  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < daq_cfg_pkg::SAMPLES_PER_BEAT; i++) begin
      beat_sum = beat_sum + beat.samples[i];
    end
  end

  assign charge_sum = (new_frame ? '0 : charge_q) + beat_sum;
  assign charge_next = charge_sum[daq_cfg_pkg::CHARGE_W] ? '1
                                                         : charge_sum[daq_cfg_pkg::CHARGE_W-1:0];

  assign len_hit = evt.beat && (cur_len + 1'b1 == max_len);
  assign close_len = evt.beat ? cur_len + 1'b1 : cur_len;
  assign close_charge = evt.beat ? charge_next : charge_q;

  assign sample_push = evt.beat;
  assign sample_word = beat.samples;
  assign pair_push = len_hit || (evt.last_missing && !new_frame);

  assign finfo.first = new_frame ? evt.start : first_q;
  assign finfo.cont = len_hit;
  assign finfo.gain_type = info.gain_type;
  assign finfo.spare = 1'b0;

  always_comb begin
    pair.line0.header_id = daq_cfg_pkg::HEADER_ID;
    pair.line0.ch_id = CHANNEL_ID[7:0];
    pair.line0.frame_len = close_len;
    pair.line0.frame_info = finfo;
    pair.line0.trigger_type = info.trigger_type;
    pair.line0.pad = '0;
    pair.line1.timestamp = info.timestamp[31:0];
    pair.line1.charge_sum = close_charge;
    pair.line1.trig_config = info.trig_config;
    pair.footer.timestamp = info.timestamp[47:32];
    pair.footer.object_id = object_id;
    pair.footer.footer_id = daq_cfg_pkg::FOOTER_ID;
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      cfg_ack <= 1'b0;
      max_len <= clamp_len(daq_cfg_pkg::DEFAULT_MAX_LEN);
      trig_open <= 1'b0;
      cur_len <= '0;
      object_id <= '0;
      frame_has_beat <= 1'b0;
    end else begin
      if (cfg_write) begin
        cfg_ack <= 1'b1;
        max_len <= clamp_len(cfg_max_len);
      end else if (cfg_ack && !cfg_req) begin
        cfg_ack <= 1'b0;
      end
      if (evt.start) begin
        trig_open <= 1'b1;
      end else if (evt.last_missing) begin
        trig_open <= 1'b0;
      end
      if (len_hit || evt.last_missing) begin
        cur_len <= '0;
      end else if (evt.beat) begin
        cur_len <= cur_len + 1'b1;
      end
      // tracks buffered samples that no pair has claimed yet
      if (pair_push) begin
        frame_has_beat <= 1'b0;
      end else if (sample_push) begin
        frame_has_beat <= 1'b1;
      end
      // id moves on once the whole trigger is out
      if (cfg_write) begin
        object_id <= '0;
      end else if (evt.last_missing) begin
        object_id <= object_id + 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (evt.beat) begin
      charge_q <= charge_next;
      if (new_frame) begin
        first_q <= evt.start;
        first_beat_q <= beat;
      end
    end
  end

  // a closed frame owns at least one sample in the buffer
  assert property (@(posedge ACLK) disable iff (ARESET)
    pair_push |-> sample_push || frame_has_beat);

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 16
) (
  input  logic             ACLK,
  input  logic             ARESET,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             empty
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;

  // full counts a push in progress, so a writer one cycle behind never overruns
  assign full = (count == DEPTH) || (count == DEPTH - 1 && push);
  assign empty = (count == '0);
  assign dout = mem[rd_ptr];

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  assert property (@(posedge ACLK) disable iff (ARESET) !(push && count == DEPTH));
  assert property (@(posedge ACLK) disable iff (ARESET) !(pop && empty));

endmodule

`default_nettype wire

// File: logic/trigger_decode.sv
`timescale 1ns/1ns
`default_nettype none

module trigger_decode (
  input  logic                       ACLK,
  input  logic                       ARESET,
  input  daq_frame_pkg::trig_beat_t  s_tdata,
  input  logic                       s_tvalid,
  input  logic                       s_tready,
  output daq_frame_pkg::beat_evt_t   evt,
  output daq_frame_pkg::trig_beat_t  beat
);

  logic open_q;
  logic accept;
  logic closing;

  assign accept = s_tvalid && s_tready;
  // a stall keeps valid high, so only a valid-low cycle ends the trigger
  assign closing = !s_tvalid && open_q;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      open_q <= 1'b0;
      evt <= '0;
    end else begin
      evt.valid <= accept || closing;
      evt.beat <= accept;
      evt.start <= accept && !open_q;
      evt.last_missing <= closing;
      if (accept) begin
        open_q <= 1'b1;
      end else if (!s_tvalid) begin
        open_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      beat <= s_tdata;
    end
  end

  // source must hold the beat through a stall
  assert property (@(posedge ACLK) disable iff (ARESET)
    s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata));

endmodule

`default_nettype wire
